/* simplebus_testdata.txt */
# Columns: opcode address data expected, hex values, "-" for an unused column, rnd = $random fill
# W write, R read, P pwm check (data = cycles between ticks, expected = high cycles), U unmapped
W 00000000 12345678 -
W 00000004 deadbeef -
W 0000003c a5a55a5a -
R 00000000 - 12345678
R 00000004 - deadbeef
R 0000003c - a5a55a5a
W 00000010 rnd -
W 00000014 rnd -
W 00000018 rnd -
W 0000001c rnd -
R 00000010 - rnd
R 00000014 - rnd
R 00000018 - rnd
R 0000001c - rnd
W 00001000 0000abcd -
R 00001000 - 0000abcd
W 00001000 00000009 -
R 00001000 - 00000009
W 00001004 ffff0004 -
R 00001004 - 00000004
R 00001008 - 00000000
R 00002000 - 00000000
U 00000040 11111111 -
U 00001010 00000077 -
U 00003000 cafef00d -
U 00000040 - -
U 00001ffc - -
U 00002010 - -
R 00000000 - 12345678
R 00001000 - 00000009
R 00001004 - 00000004
W 00001008 00000001 -
R 00001008 - 00000001
P 00000000 0000000a 00000004
W 00001000 00000005 -
W 00001004 00000005 -
P 00000000 00000006 00000005
W 00001004 00000000 -
P 00000000 00000006 00000000
W 00001008 00000000 -
P 00000000 00000000 00000000
R 00002000 - 00000000

/* filelist.f */
+incdir+.
simplebus_pkg.sv
simplebus_interconnect.sv
scratch_ram.sv
control_registers.sv
pwm_timer.sv
simplebus_subsystem.sv
simplebus_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -f filelist.f --top-module simplebus_subsystem_tb \
        -Mdir obj_dir -o simv > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
        cat "$BUILD_LOG"
        echo "Verilator build did not succeed"
        exit 1
fi

./obj_dir/simv > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "TEST FAILED" "$SIM_LOG"; then
        exit 1
fi
if [ $sim_status -ne 0 ]; then
        echo "Simulation exited with status $sim_status"
        exit 1
fi
exit 0

/* simplebus_subsystem_tb.sv */
// Testbench for the simple bus subsystem, driven by a data file of bus operations
module simplebus_subsystem_tb;

        timeunit 1ns;
        timeprecision 100ps;

        localparam int          READY_TIMEOUT   = 20;
        localparam int          READ_TIMEOUT    = 20;
        localparam int          UNMAPPED_WINDOW = 10;
        localparam int          TICK_TIMEOUT    = 200;
        localparam int          DISABLED_WINDOW = 32;
        localparam logic [15:0] READ_LATENCY    = 16'd3;

        logic                        clock;
        logic                        rst_n;
        simplebus_pkg::sb_request_t  request;
        simplebus_pkg::sb_response_t response;
        logic                        pwm_out;
        logic                        period_tick;

        // Random RAM fill values kept by address for readback
        simplebus_pkg::sb_data_t fill_value [simplebus_pkg::sb_address_t];
        integer                  seed;

        simplebus_subsystem u_dut (
                .clock       (clock),
                .rst_n       (rst_n),
                .request     (request),
                .response    (response),
                .pwm_out     (pwm_out),
                .period_tick (period_tick)
        );

        always #4 clock = ~clock;

        task automatic stop_failed();
                $display("TEST FAILED");
                $fatal(1, "stopped at the first error");
        endtask

        task automatic report_problem(input string what);
                $display("%s", what);
                stop_failed();
        endtask

        task automatic check_data(input string name, input simplebus_pkg::sb_data_t actual,
                                  input simplebus_pkg::sb_data_t expected);
                if (actual !== expected) begin
                        $display("error: time %0d ns, %s expected %h, got %h",
                                 $time, name, expected, actual);
                        stop_failed();
                end
        endtask

        task automatic check_count(input string name, input logic [15:0] actual,
                                   input logic [15:0] expected);
                if (actual !== expected) begin
                        $display("error: time %0d ns, %s expected %0d, got %0d",
                                 $time, name, expected, actual);
                        stop_failed();
                end
        endtask

        task automatic check_bit(input string name, input logic actual, input logic expected);
                if (actual !== expected) begin
                        $display("error: time %0d ns, %s expected %b, got %b",
                                 $time, name, expected, actual);
                        stop_failed();
                end
        endtask

        // Master may only issue while ready is high
        task automatic wait_ready();
                int cycles;
                cycles = 0;
                while (response.ready !== 1'b1 && cycles < READY_TIMEOUT) begin
                        @(posedge clock);
                        #1;
                        cycles++;
                end
                if (response.ready !== 1'b1) begin
                        report_problem("response.ready did not go high within the timeout");
                end
        endtask

        task automatic bus_write(input simplebus_pkg::sb_address_t address,
                                 input simplebus_pkg::sb_data_t data);
                wait_ready();
                request.address      = address;
                request.write_data   = data;
                request.write_strobe = 1'b1;
                @(posedge clock);
                #1;
                request = '0;
        endtask

        task automatic bus_read(input simplebus_pkg::sb_address_t address,
                                output simplebus_pkg::sb_data_t data, output logic [15:0] latency);
                int   cycles;
                logic seen;
                wait_ready();
                request.address     = address;
                request.read_strobe = 1'b1;
                cycles = 0;
                seen = 1'b0;
                while (!seen && cycles < READ_TIMEOUT) begin
                        @(posedge clock);
                        #1;
                        request = '0;
                        cycles++;
                        seen = response.read_valid;
                end
                if (!seen) begin
                        report_problem($sformatf("no read_valid for the read at %h", address));
                end
                data = response.read_data;
                latency = 16'(cycles);
        endtask

        // An unmapped read must stay silent for the whole window
        task automatic unmapped_read(input simplebus_pkg::sb_address_t address);
                wait_ready();
                request.address     = address;
                request.read_strobe = 1'b1;
                for (int i = 0; i < UNMAPPED_WINDOW; i++) begin
                        @(posedge clock);
                        #1;
                        request = '0;
                        check_bit("response.read_valid", response.read_valid, 1'b0);
                end
        endtask

        task automatic wait_tick();
                int   cycles;
                logic seen;
                cycles = 0;
                seen = 1'b0;
                while (!seen && cycles < TICK_TIMEOUT) begin
                        @(posedge clock);
                        #1;
                        cycles++;
                        seen = period_tick;
                end
                if (!seen) begin
                        report_problem("period_tick did not arrive within the timeout");
                end
        endtask

        task automatic watch_disabled();
                for (int i = 0; i < DISABLED_WINDOW; i++) begin
                        @(posedge clock);
                        #1;
                        check_bit("pwm_out", pwm_out, 1'b0);
                        check_bit("period_tick", period_tick, 1'b0);
                end
        endtask

        // Spacing of zero means the timer is expected to be off
        task automatic measure_pwm(input logic [15:0] spacing_expected,
                                   input logic [15:0] high_expected);
                int   spacing;
                int   high;
                logic ended;
                if (spacing_expected == 16'd0) begin
                        watch_disabled();
                end else begin
                        // Skip the first tick so that all settings are in place
                        wait_tick();
                        wait_tick();
                        spacing = 0;
                        high = 0;
                        ended = 1'b0;
                        while (!ended && spacing < TICK_TIMEOUT) begin
                                if (pwm_out) begin
                                        high++;
                                end
                                spacing++;
                                @(posedge clock);
                                #1;
                                ended = period_tick;
                        end
                        if (!ended) begin
                                report_problem("second period_tick did not arrive in time");
                        end
                        check_count("period_tick spacing", 16'(spacing), spacing_expected);
                        check_count("pwm_out high cycles", 16'(high), high_expected);
                end
        endtask

        task automatic run_line(input string op, input simplebus_pkg::sb_address_t address,
                                input string data_text, input string expected_text);
                simplebus_pkg::sb_data_t data;
                simplebus_pkg::sb_data_t expected;
                simplebus_pkg::sb_data_t read_value;
                logic [15:0]             latency;
                data = '0;
                expected = '0;
                if (data_text == "rnd") begin
                        data = $random(seed);
                        fill_value[address] = data;
                end else if (data_text != "-") begin
                        if ($sscanf(data_text, "%h", data) != 1) begin
                                report_problem({"bad data value in data file: ", data_text});
                        end
                end
                if (expected_text == "rnd") begin
                        if (!fill_value.exists(address)) begin
                                report_problem("readback of a random word that was never written");
                        end
                        expected = fill_value[address];
                end else if (expected_text != "-") begin
                        if ($sscanf(expected_text, "%h", expected) != 1) begin
                                report_problem({"bad expected value in data file: ", expected_text});
                        end
                end
                if (op == "W") begin
                        bus_write(address, data);
                end else if (op == "R") begin
                        bus_read(address, read_value, latency);
                        check_count("read latency", latency, READ_LATENCY);
                        check_data("response.read_data", read_value, expected);
                end else if (op == "P") begin
                        measure_pwm(data[15:0], expected[15:0]);
                end else if (op == "U") begin
                        if (data_text == "-") begin
                                unmapped_read(address);
                        end else begin
                                bus_write(address, data);
                        end
                end else begin
                        report_problem({"unknown opcode in data file: ", op});
                end
        endtask

        initial begin
                string                      line;
                string                      op;
                string                      data_text;
                string                      expected_text;
                simplebus_pkg::sb_address_t address;
                int                         fd;
                int                         status;
                clock = 1'b0;
                rst_n = 1'b0;
                request = '0;
                seed = 12;
                repeat (4) @(posedge clock);
                #1;
                check_bit("response.ready", response.ready, 1'b0);
                repeat (4) @(posedge clock);
                #1;
                rst_n = 1'b1;
                check_bit("response.read_valid", response.read_valid, 1'b0);
                check_bit("pwm_out", pwm_out, 1'b0);
                check_bit("period_tick", period_tick, 1'b0);
                wait_ready();

                fd = $fopen("simplebus_testdata.txt", "r");
                if (fd == 0) begin
                        report_problem("could not open simplebus_testdata.txt");
                end
                while (!$feof(fd)) begin
                        line = "";
                        status = $fgets(line, fd);
                        // Skip comments and blank lines
                        if (status != 0 && line.len() > 1 && line.getc(0) != "#") begin
                                if ($sscanf(line, "%s %h %s %s", op, address, data_text,
                                            expected_text) != 4) begin
                                        report_problem({"malformed line in data file: ", line});
                                end
                                run_line(op, address, data_text, expected_text);
                        end
                end
                $fclose(fd);

                $display("TEST OK");
                $finish;
        end

endmodule

/* simplebus_subsystem.sv */
// Peripheral subsystem joining the bus interconnect, scratch RAM, control registers and PWM timer
`include "simplebus_defines.svh"

module simplebus_subsystem (
        input  logic                        clock,
        input  logic                        rst_n,
        input  simplebus_pkg::sb_request_t  request,
        output simplebus_pkg::sb_response_t response,
        output logic                        pwm_out,
        output logic                        period_tick
);

        // Slave ports of the interconnect
        localparam int RAM_SLAVE  = 0;
        localparam int CTRL_SLAVE = 1;
        localparam int PWM_SLAVE  = 2;

        simplebus_pkg::sb_request_t  slave_request [`SB_SLAVE_COUNT];
        simplebus_pkg::sb_response_t slave_response [`SB_SLAVE_COUNT];
        simplebus_pkg::pwm_config_t  pwm_config;

        simplebus_interconnect #(
                .SLAVE_COUNT (`SB_SLAVE_COUNT),
                .SLAVE_LOW   ('{`SB_RAM_LOW, `SB_CTRL_LOW, `SB_PWM_LOW}),
                .SLAVE_HIGH  ('{`SB_RAM_HIGH, `SB_CTRL_HIGH, `SB_PWM_HIGH})
        ) u_interconnect (
                .clock          (clock),
                .rst_n          (rst_n),
                .request        (request),
                .slave_request  (slave_request),
                .slave_response (slave_response),
                .response       (response)
        );

        scratch_ram u_scratch_ram (
                .clock    (clock),
                .rst_n    (rst_n),
                .request  (slave_request[RAM_SLAVE]),
                .response (slave_response[RAM_SLAVE])
        );

        control_registers u_control_registers (
                .clock      (clock),
                .rst_n      (rst_n),
                .request    (slave_request[CTRL_SLAVE]),
                .response   (slave_response[CTRL_SLAVE]),
                .pwm_config (pwm_config)
        );

        pwm_timer u_pwm_timer (
                .clock       (clock),
                .rst_n       (rst_n),
                .request     (slave_request[PWM_SLAVE]),
                .response    (slave_response[PWM_SLAVE]),
                .pwm_config  (pwm_config),
                .pwm_out     (pwm_out),
                .period_tick (period_tick)
        );

endmodule

/* pwm_timer.sv */
// PWM timer with a free-running counter, period tick and bus readable count
`include "simplebus_defines.svh"

module pwm_timer (
        input  logic                        clock,
        input  logic                        rst_n,
        input  simplebus_pkg::sb_request_t  request,
        output simplebus_pkg::sb_response_t response,
        input  simplebus_pkg::pwm_config_t  pwm_config,
        output logic                        pwm_out,
        output logic                        period_tick
);

        logic [15:0]             count_q;
        simplebus_pkg::sb_data_t read_data_q;
        logic                    read_valid_q;

        // Counts 0..period, so one period is period + 1 cycles
        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        count_q <= '0;
                end else if (!pwm_config.enable) begin
                        count_q <= '0;
                end else if (count_q >= pwm_config.period) begin
                        // Also catches a period lowered below the running count
                        count_q <= '0;
                end else begin
                        count_q <= count_q + 16'd1;
                end
        end

        assign period_tick = pwm_config.enable && (count_q == 16'd0);
        assign pwm_out     = pwm_config.enable && (count_q < pwm_config.compare);

        // Count snapshot, writes to this window are ignored
        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        read_data_q  <= '0;
                        read_valid_q <= 1'b0;
                end else begin
                        read_valid_q <= request.read_strobe;
                        if (request.read_strobe && (request.address[3:2] == `SB_PWM_COUNT)) begin
                                read_data_q <= {16'h0, count_q};
                        end else begin
                                read_data_q <= '0;
                        end
                end
        end

        assign response = '{
                read_data:  read_data_q,
                read_valid: read_valid_q,
                ready:      1'b1
        };

endmodule

/* control_registers.sv */
// Control register slave holding the PWM period, compare and enable settings
`include "simplebus_defines.svh"

module control_registers (
        input  logic                        clock,
        input  logic                        rst_n,
        input  simplebus_pkg::sb_request_t  request,
        output simplebus_pkg::sb_response_t response,
        output simplebus_pkg::pwm_config_t  pwm_config
);

        logic [1:0]                  offset;
        simplebus_pkg::pwm_config_t  config_q;
        simplebus_pkg::sb_data_t     read_data_q;
        logic                        read_valid_q;

        assign offset = request.address[3:2];

        // Register writes
        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        config_q <= '0;
                end else if (request.write_strobe) begin
                        case (offset)
                                `SB_REG_PERIOD:  config_q.period  <= request.write_data[15:0];
                                `SB_REG_COMPARE: config_q.compare <= request.write_data[15:0];
                                `SB_REG_ENABLE:  config_q.enable  <= request.write_data[0];
                                default: ;
                        endcase
                end
        end

        // Readback, zero-extended to a full word
        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        read_data_q  <= '0;
                        read_valid_q <= 1'b0;
                end else begin
                        read_valid_q <= request.read_strobe;
                        read_data_q  <= '0;
                        if (request.read_strobe) begin
                                case (offset)
                                        `SB_REG_PERIOD:  read_data_q <= {16'h0, config_q.period};
                                        `SB_REG_COMPARE: read_data_q <= {16'h0, config_q.compare};
                                        `SB_REG_ENABLE:  read_data_q <= {31'h0, config_q.enable};
                                        default:         read_data_q <= '0;
                                endcase
                        end
                end
        end

        assign pwm_config = config_q;

        assign response = '{
                read_data:  read_data_q,
                read_valid: read_valid_q,
                ready:      1'b1
        };

endmodule

/* scratch_ram.sv */
// Word-addressed scratch RAM slave on the simple bus
`include "simplebus_defines.svh"

module scratch_ram (
        input  logic                        clock,
        input  logic                        rst_n,
        input  simplebus_pkg::sb_request_t  request,
        output simplebus_pkg::sb_response_t response
);

        localparam int INDEX_BITS = $clog2(`SB_RAM_WORDS);

        simplebus_pkg::sb_data_t memory [`SB_RAM_WORDS];
        logic [INDEX_BITS-1:0]   index;
        simplebus_pkg::sb_data_t read_data_q;
        logic                    read_valid_q;

        // Word index, byte offset dropped
        assign index = request.address[INDEX_BITS+1:2];

        always_ff @(posedge clock) begin
                if (request.write_strobe) begin
                        memory[index] <= request.write_data;
                end
        end

        // Data stays zero unless answering a read
        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        read_data_q  <= '0;
                        read_valid_q <= 1'b0;
                end else begin
                        read_valid_q <= request.read_strobe;
                        if (request.read_strobe) begin
                                read_data_q <= memory[index];
                        end else begin
                                read_data_q <= '0;
                        end
                end
        end

        // Never stalls
        assign response = '{
                read_data:  read_data_q,
                read_valid: read_valid_q,
                ready:      1'b1
        };

endmodule

/* simplebus_interconnect.sv */
// Registered one-to-many address decoder with OR/AND merge of the slave responses
`include "simplebus_defines.svh"

module simplebus_interconnect #(
        parameter int SLAVE_COUNT = `SB_SLAVE_COUNT,
        parameter simplebus_pkg::sb_address_t SLAVE_LOW [SLAVE_COUNT] = '{default: 32'h0},
        parameter simplebus_pkg::sb_address_t SLAVE_HIGH [SLAVE_COUNT] =
                '{default: 32'hFFFF_FFFF}
) (
        input  logic                        clock,
        input  logic                        rst_n,
        input  simplebus_pkg::sb_request_t  request,
        output simplebus_pkg::sb_request_t  slave_request [SLAVE_COUNT],
        input  simplebus_pkg::sb_response_t slave_response [SLAVE_COUNT],
        output simplebus_pkg::sb_response_t response
);

        logic [SLAVE_COUNT-1:0]      window_hit;
        simplebus_pkg::sb_response_t merged;

        // Window match per slave
        always_comb begin
                for (int i = 0; i < SLAVE_COUNT; i++) begin
                        window_hit[i] = (request.address >= SLAVE_LOW[i]) &&
                                        (request.address < SLAVE_HIGH[i]);
                end
        end

        // Idle slaves drive zero data, so OR is enough to pick the answer
        always_comb begin
                merged = '0;
                merged.ready = 1'b1;
                for (int i = 0; i < SLAVE_COUNT; i++) begin
                        merged.read_data  = merged.read_data | slave_response[i].read_data;
                        merged.read_valid = merged.read_valid | slave_response[i].read_valid;
                        merged.ready      = merged.ready & slave_response[i].ready;
                end
        end

        // Request fan-out, one clock
        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < SLAVE_COUNT; i++) begin
                                slave_request[i] <= '0;
                        end
                end else begin
                        for (int i = 0; i < SLAVE_COUNT; i++) begin
                                if (window_hit[i]) begin
                                        slave_request[i] <= request;
                                end else begin
                                        slave_request[i] <= '0;
                                end
                        end
                end
        end

        // Merged response back to the master, one clock
        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        response <= '0;
                end else begin
                        response <= merged;
                end
        end

endmodule

/* simplebus_pkg.sv */
// Simple strobe bus types shared by the interconnect, the slaves and the PWM settings
package simplebus_pkg;

        // Byte address and data word of the bus
        typedef logic [31:0] sb_address_t;
        typedef logic [31:0] sb_data_t;

        // Master to slave direction
        typedef struct packed {
                sb_address_t address;
                logic        write_strobe;
                logic        read_strobe;
                sb_data_t    write_data;
        } sb_request_t;

        // Slave to master direction
        typedef struct packed {
                sb_data_t read_data;
                logic     read_valid;
                logic     ready;
        } sb_response_t;

        // PWM settings held by the register block
        typedef struct packed {
                logic [15:0] period;
                logic [15:0] compare;
                logic        enable;
        } pwm_config_t;

endpackage

/* simplebus_defines.svh */
// Address map, RAM size and register offsets of the simple bus subsystem
`ifndef SIMPLEBUS_DEFINES_SVH
`define SIMPLEBUS_DEFINES_SVH

`define SB_SLAVE_COUNT 3

// Windows include the low address and exclude the high one
`define SB_RAM_LOW   32'h0000_0000
`define SB_RAM_HIGH  32'h0000_0040
`define SB_CTRL_LOW  32'h0000_1000
`define SB_CTRL_HIGH 32'h0000_1010
`define SB_PWM_LOW   32'h0000_2000
`define SB_PWM_HIGH  32'h0000_2010

`define SB_RAM_WORDS 16

// Word offsets inside the control window
`define SB_REG_PERIOD  2'd0
`define SB_REG_COMPARE 2'd1
`define SB_REG_ENABLE  2'd2

// Word offset inside the PWM window, read only
`define SB_PWM_COUNT 2'd0

`endif
